/* pipe_pkg.sv */
package pipe_pkg;

    localparam int xlen = 64;
    localparam int addr_w = 13;
    localparam int ram_words = 1 << (addr_w - 3);
    localparam int ram_wait = 2;
    localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;
    localparam logic [1:0] axi_okay = 2'b00;

    typedef enum logic [3:0] {
        MEM_NOP,
        LB,
        LH,
        LW,
        LD,
        LBU,
        LHU,
        LWU,
        SB,
        SH,
        SW,
        SD
    } mem_op_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_EXE,
        WB_MEM
    } wb_sel_e;

    // executed instruction as it leaves the execute stage.
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] exe_result; // address for loads and stores.
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
        mem_op_e         mem_op;
        wb_sel_e         wb_sel;
    } exe_mem_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] wb_value;
        logic            wb_en;
    } mem_wb_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [2:0]      prot;
    } axi_aw_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [7:0]      strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [2:0]      prot;
    } axi_ar_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [1:0]      resp;
    } axi_r_t;

    localparam exe_mem_t exe_mem_reset = '{
        pc: reset_pc,
        exe_result: '0,
        store_data: '0,
        rd: '0,
        mem_op: MEM_NOP,
        wb_sel: WB_NONE
    };

    localparam mem_wb_t mem_wb_reset = '0;

endpackage

/* pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic,
    parameter payload_t reset_value = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  logic     squash,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_out <= 1'b0;
            data_out  <= reset_value;
        end else if (enable) begin
            valid_out <= valid_in && !squash; // squashed record becomes a bubble.
            data_out  <= data_in;
        end
    end

    // a stalled stage must present the same record next cycle.
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst)
        !enable |=> $stable(data_out) && $stable(valid_out)
    ) else $error("pipe_reg changed while enable was low");

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  pipe_pkg::exe_mem_t  rec,
    output logic                stall,
    output logic                wb_valid,
    output pipe_pkg::mem_wb_t   wb_rec,
    output pipe_pkg::axi_aw_t   aw,
    output logic                awvalid,
    input  logic                awready,
    output pipe_pkg::axi_w_t    w,
    output logic                wvalid,
    input  logic                wready,
    input  pipe_pkg::axi_b_t    b,
    input  logic                bvalid,
    output logic                bready,
    output pipe_pkg::axi_ar_t   ar,
    output logic                arvalid,
    input  logic                arready,
    input  pipe_pkg::axi_r_t    r,
    input  logic                rvalid,
    output logic                rready
);

    typedef enum logic [1:0] {st_idle, st_req, st_resp, st_done} state_e;

    state_e                    state;
    logic                      is_mem;
    logic                      is_store;
    logic [7:0]                lane_mask;
    logic [2:0]                align_mask;
    logic [5:0]                shamt;
    logic [pipe_pkg::xlen-1:0] load_q;
    logic [pipe_pkg::xlen-1:0] lane_data;
    logic [pipe_pkg::xlen-1:0] load_val;

    always_comb begin
        is_mem   = rec.mem_op != pipe_pkg::MEM_NOP;
        is_store = rec.mem_op inside {pipe_pkg::SB, pipe_pkg::SH, pipe_pkg::SW, pipe_pkg::SD};
        case (rec.mem_op)
            pipe_pkg::LB, pipe_pkg::LBU, pipe_pkg::SB: begin
                lane_mask  = 8'h01;
                align_mask = 3'b000;
            end
            pipe_pkg::LH, pipe_pkg::LHU, pipe_pkg::SH: begin
                lane_mask  = 8'h03;
                align_mask = 3'b001;
            end
            pipe_pkg::LW, pipe_pkg::LWU, pipe_pkg::SW: begin
                lane_mask  = 8'h0f;
                align_mask = 3'b011;
            end
            default: begin
                lane_mask  = 8'hff;
                align_mask = 3'b111;
            end
        endcase
    end

    assign shamt = {rec.exe_result[2:0], 3'b000}; // byte offset in bits.

    assign aw = '{addr: rec.exe_result, prot: 3'b000};
    assign ar = '{addr: rec.exe_result, prot: 3'b000};
    assign w  = '{data: rec.store_data << shamt, strb: lane_mask << rec.exe_result[2:0]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= st_idle;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                st_idle: if (valid && is_mem) begin
                    state   <= st_req;
                    awvalid <= is_store;
                    wvalid  <= is_store;
                    arvalid <= !is_store;
                end
                st_req: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (arready) arvalid <= 1'b0;
                    if ((!awvalid || awready) && (!wvalid || wready) && (!arvalid || arready))
                        state <= st_resp;
                end
                st_resp: if ((bvalid && bready) || (rvalid && rready)) state <= st_done;
                default: state <= st_idle; // done lasts one cycle.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid && rready) load_q <= r.data;
    end

    assign bready = state == st_resp;
    assign rready = state == st_resp;

    // hold the record until its response has been captured.
    assign stall    = valid && is_mem && state != st_done;
    assign wb_valid = valid && !stall;

    assign lane_data = load_q >> shamt;

    always_comb begin
        case (rec.mem_op)
            pipe_pkg::LB:  load_val = {{56{lane_data[7]}}, lane_data[7:0]};
            pipe_pkg::LH:  load_val = {{48{lane_data[15]}}, lane_data[15:0]};
            pipe_pkg::LW:  load_val = {{32{lane_data[31]}}, lane_data[31:0]};
            pipe_pkg::LBU: load_val = {56'b0, lane_data[7:0]};
            pipe_pkg::LHU: load_val = {48'b0, lane_data[15:0]};
            pipe_pkg::LWU: load_val = {32'b0, lane_data[31:0]};
            default:       load_val = lane_data;
        endcase
        wb_rec.pc       = rec.pc;
        wb_rec.rd       = rec.rd;
        wb_rec.wb_en    = rec.wb_sel != pipe_pkg::WB_NONE;
        wb_rec.wb_value = (rec.wb_sel == pipe_pkg::WB_MEM) ? load_val : rec.exe_result;
    end

    a_aligned: assert property (
        @(posedge clk) disable iff (!rst)
        valid && is_mem |-> (rec.exe_result[2:0] & align_mask) == 3'b000
    ) else $error("misaligned memory access");

    a_one_request: assert property (
        @(posedge clk) disable iff (!rst) !(awvalid && arvalid)
    ) else $error("read and write requested together");

    a_resp_okay: assert property (
        @(posedge clk) disable iff (!rst)
        (bvalid |-> b.resp == pipe_pkg::axi_okay) and (rvalid |-> r.resp == pipe_pkg::axi_okay)
    ) else $error("memory returned an error response");

endmodule

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic               clk,
    input  logic               rst,
    input  pipe_pkg::axi_aw_t  aw,
    input  logic               awvalid,
    output logic               awready,
    input  pipe_pkg::axi_w_t   w,
    input  logic               wvalid,
    output logic               wready,
    output pipe_pkg::axi_b_t   b,
    output logic               bvalid,
    input  logic               bready,
    input  pipe_pkg::axi_ar_t  ar,
    input  logic               arvalid,
    output logic               arready,
    output pipe_pkg::axi_r_t   r,
    output logic               rvalid,
    input  logic               rready
);

    logic [pipe_pkg::xlen-1:0]  mem [pipe_pkg::ram_words];
    logic [pipe_pkg::xlen-1:0]  rdata_q;
    logic [pipe_pkg::addr_w-4:0] widx;
    logic [pipe_pkg::addr_w-4:0] ridx;
    logic                        busy;
    logic                        is_wr;
    logic [3:0]                  wait_cnt;
    logic                        aw_fire;
    logic                        ar_fire;

    assign widx = aw.addr[pipe_pkg::addr_w-1:3];
    assign ridx = ar.addr[pipe_pkg::addr_w-1:3];

    // address and data are taken in the same cycle.
    assign awready = awvalid && wvalid && !busy;
    assign wready  = awvalid && wvalid && !busy;
    assign arready = arvalid && !awvalid && !busy;

    assign aw_fire = awvalid && awready;
    assign ar_fire = arvalid && arready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy     <= 1'b0;
            is_wr    <= 1'b0;
            wait_cnt <= '0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            if (aw_fire || ar_fire) begin
                busy     <= 1'b1;
                is_wr    <= aw_fire;
                wait_cnt <= 4'(pipe_pkg::ram_wait);
            end else if (busy && wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 4'd1;
                if (wait_cnt == 4'd1) begin
                    bvalid <= is_wr; // response after the wait.
                    rvalid <= !is_wr;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                busy   <= 1'b0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                busy   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            for (int i = 0; i < 8; i++) begin
                if (w.strb[i]) mem[widx][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
        if (ar_fire) rdata_q <= mem[ridx];
    end

    assign b = '{resp: pipe_pkg::axi_okay};
    assign r = '{data: rdata_q, resp: pipe_pkg::axi_okay};

    a_w_with_aw: assert property (
        @(posedge clk) disable iff (!rst) wvalid |-> awvalid
    ) else $error("write data without write address");

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      we,
    input  logic [4:0]                waddr,
    input  logic [pipe_pkg::xlen-1:0] wdata,
    input  logic [4:0]                rs1_addr,
    input  logic [4:0]                rs2_addr,
    output logic [pipe_pkg::xlen-1:0] rs1_data,
    output logic [pipe_pkg::xlen-1:0] rs2_data
);

    logic [pipe_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata; // x0 stays zero.
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

/* mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  pipe_pkg::exe_mem_t        in_rec,
    input  logic                      squash,
    output logic                      in_ready,
    output logic                      commit_valid,
    output pipe_pkg::mem_wb_t         commit,
    input  logic [4:0]                rs1_addr,
    input  logic [4:0]                rs2_addr,
    output logic [pipe_pkg::xlen-1:0] rs1_data,
    output logic [pipe_pkg::xlen-1:0] rs2_data
);

    logic               enable;
    logic               stall;
    logic               em_valid;
    pipe_pkg::exe_mem_t em_rec;
    logic               wb_valid;
    pipe_pkg::mem_wb_t  wb_rec;
    pipe_pkg::axi_aw_t  aw;
    logic               awvalid;
    logic               awready;
    pipe_pkg::axi_w_t   w;
    logic               wvalid;
    logic               wready;
    pipe_pkg::axi_b_t   b;
    logic               bvalid;
    logic               bready;
    pipe_pkg::axi_ar_t  ar;
    logic               arvalid;
    logic               arready;
    pipe_pkg::axi_r_t   r;
    logic               rvalid;
    logic               rready;

    assign enable   = !stall;
    assign in_ready = enable;

    pipe_reg #(
        .payload_t   (pipe_pkg::exe_mem_t),
        .reset_value (pipe_pkg::exe_mem_reset)
    ) exe_mem_reg (
        .clk (clk), .rst (rst), .enable (enable), .squash (squash),
        .valid_in (in_valid), .data_in (in_rec),
        .valid_out (em_valid), .data_out (em_rec)
    );

    mem_stage mem_stage_i (
        .clk (clk), .rst (rst), .valid (em_valid), .rec (em_rec),
        .stall (stall), .wb_valid (wb_valid), .wb_rec (wb_rec),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready),
        .b (b), .bvalid (bvalid), .bready (bready),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid), .rready (rready)
    );

    data_ram data_ram_i (
        .clk (clk), .rst (rst),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready),
        .b (b), .bvalid (bvalid), .bready (bready),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid), .rready (rready)
    );

    // always loads so a stall arrives here as a bubble.
    pipe_reg #(
        .payload_t   (pipe_pkg::mem_wb_t),
        .reset_value (pipe_pkg::mem_wb_reset)
    ) mem_wb_reg (
        .clk (clk), .rst (rst), .enable (1'b1), .squash (1'b0),
        .valid_in (wb_valid), .data_in (wb_rec),
        .valid_out (commit_valid), .data_out (commit)
    );

    reg_file reg_file_i (
        .clk (clk), .rst (rst),
        .we (commit_valid && commit.wb_en), .waddr (commit.rd), .wdata (commit.wb_value),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .rs1_data (rs1_data), .rs2_data (rs2_data)
    );

endmodule

/* tb_mem_wb.sv */
`timescale 1ns/1ps

module tb_mem_wb;

    localparam int win_base = 'h200;
    localparam int win_bytes = 256;
    localparam int num_recs = 2000;
    localparam int wait_limit = 100;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    pipe_pkg::exe_mem_t        in_rec;
    logic                      squash;
    logic                      in_ready;
    logic                      commit_valid;
    pipe_pkg::mem_wb_t         commit;
    logic [4:0]                rs1_addr;
    logic [4:0]                rs2_addr;
    logic [pipe_pkg::xlen-1:0] rs1_data;
    logic [pipe_pkg::xlen-1:0] rs2_data;

    logic [7:0]                mem_model [win_bytes];
    logic [pipe_pkg::xlen-1:0] reg_model [32];
    pipe_pkg::mem_wb_t         expect_q [$];
    logic                      last_mem; // last accepted record touches memory.
    logic [pipe_pkg::xlen-1:0] next_pc;

    mem_wb_top mem_wb_top_i (
        .clk (clk), .rst (rst),
        .in_valid (in_valid), .in_rec (in_rec), .squash (squash), .in_ready (in_ready),
        .commit_valid (commit_valid), .commit (commit),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .rs1_data (rs1_data), .rs2_data (rs2_data)
    );

    always #20 clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else
            stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, want));
    endtask

    function automatic int access_bytes(input pipe_pkg::mem_op_e op);
        case (op)
            pipe_pkg::LB, pipe_pkg::LBU, pipe_pkg::SB: return 1;
            pipe_pkg::LH, pipe_pkg::LHU, pipe_pkg::SH: return 2;
            pipe_pkg::LW, pipe_pkg::LWU, pipe_pkg::SW: return 4;
            default: return 8;
        endcase
    endfunction

    // little endian gather from the byte model and extend.
    function automatic logic [63:0] model_load(input pipe_pkg::mem_op_e op, input int off);
        logic [63:0] raw;
        int          n;
        raw = '0;
        n = access_bytes(op);
        for (int i = 0; i < n; i++) begin
            raw[8*i +: 8] = mem_model[off + i];
        end
        case (op)
            pipe_pkg::LB: return {{56{raw[7]}}, raw[7:0]};
            pipe_pkg::LH: return {{48{raw[15]}}, raw[15:0]};
            pipe_pkg::LW: return {{32{raw[31]}}, raw[31:0]};
            default:      return raw; // zero extended by the gather.
        endcase
    endfunction

    function automatic pipe_pkg::exe_mem_t random_record();
        pipe_pkg::exe_mem_t rec;
        int                 kind;
        int                 size;
        kind = $urandom % 10;
        rec.pc = next_pc;
        rec.rd = 5'($urandom);
        rec.store_data = {$urandom, $urandom};
        rec.exe_result = {$urandom, $urandom};
        rec.mem_op = pipe_pkg::MEM_NOP;
        rec.wb_sel = ($urandom % 5 == 0) ? pipe_pkg::WB_NONE : pipe_pkg::WB_EXE;
        if (kind >= 4) begin
            if (kind < 7) begin
                rec.mem_op = pipe_pkg::mem_op_e'(4'(1 + $urandom % 7)); // LB to LWU.
                rec.wb_sel = pipe_pkg::WB_MEM;
            end else begin
                rec.mem_op = pipe_pkg::mem_op_e'(4'(8 + $urandom % 4)); // SB to SD.
                rec.wb_sel = pipe_pkg::WB_NONE;
            end
            size = access_bytes(rec.mem_op);
            rec.exe_result = 64'(win_base + (($urandom % win_bytes) & ~(size - 1)));
        end
        return rec;
    endfunction

    task automatic send(input pipe_pkg::exe_mem_t rec, input logic sq);
        pipe_pkg::mem_wb_t want;
        int                waited;
        int                off;
        waited = 0;
        in_valid = 1'b1;
        in_rec = rec;
        squash = sq;
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) stop_with_error("in_ready stayed low too long");
        end
        // taken at the coming rising edge.
        last_mem = !sq && rec.mem_op != pipe_pkg::MEM_NOP;
        next_pc = next_pc + 64'd4;
        if (!sq) begin
            want.pc = rec.pc;
            want.rd = rec.rd;
            want.wb_en = rec.wb_sel != pipe_pkg::WB_NONE;
            want.wb_value = rec.exe_result;
            if (rec.mem_op != pipe_pkg::MEM_NOP) begin
                off = int'(rec.exe_result[31:0]) - win_base;
                if (rec.wb_sel == pipe_pkg::WB_MEM) want.wb_value = model_load(rec.mem_op, off);
                if (rec.mem_op >= pipe_pkg::SB) begin
                    for (int i = 0; i < access_bytes(rec.mem_op); i++) begin
                        mem_model[off + i] = rec.store_data[8*i +: 8];
                    end
                end
            end
            if (want.wb_en && want.rd != 5'd0) reg_model[want.rd] = want.wb_value;
            expect_q.push_back(want);
        end
        @(negedge clk);
        in_valid = 1'b0;
        squash = 1'b0;
    endtask

    task automatic sweep_regs();
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            rs1_addr = 5'(i);
            rs2_addr = 5'(31 - i);
            #10;
            check_value($sformatf("rs1_data x%0d", i), rs1_data, reg_model[i]);
            check_value($sformatf("rs2_data x%0d", 31 - i), rs2_data, reg_model[31 - i]);
        end
    endtask

    // commits are registered and the falling edge sees each one once.
    always @(negedge clk) begin
        pipe_pkg::mem_wb_t want;
        if (rst && commit_valid) begin
            assert (expect_q.size() > 0) else
                stop_with_error("a commit arrived with no record pending");
            want = expect_q.pop_front();
            check_value("commit.pc", commit.pc, want.pc);
            check_value("commit.rd", 64'(commit.rd), 64'(want.rd));
            check_value("commit.wb_en", 64'(commit.wb_en), 64'(want.wb_en));
            check_value("commit.wb_value", commit.wb_value, want.wb_value);
        end
        if (rst && !in_ready) begin
            assert (last_mem) else
                stop_with_error("in_ready went low behind a record without a memory access");
        end
    end

    initial begin
        pipe_pkg::exe_mem_t rec;
        int                 waited;
        void'($urandom(32'h8eb3bfce));
        clk = 1'b0;
        rst = 1'b0;
        in_valid = 1'b0;
        in_rec = '0;
        squash = 1'b0;
        rs1_addr = 5'd0;
        rs2_addr = 5'd0;
        last_mem = 1'b0;
        next_pc = pipe_pkg::reset_pc;
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_value("commit_valid", 64'(commit_valid), 64'd0);
        check_value("in_ready", 64'(in_ready), 64'd1);
        sweep_regs();

        // fill the window so every later load has defined bytes.
        for (int a = 0; a < win_bytes; a += 8) begin
            rec = '0;
            rec.pc = next_pc;
            rec.exe_result = 64'(win_base + a);
            rec.store_data = {$urandom, $urandom};
            rec.mem_op = pipe_pkg::SD;
            rec.wb_sel = pipe_pkg::WB_NONE;
            send(rec, 1'b0);
        end

        for (int n = 0; n < num_recs; n++) begin
            send(random_record(), ($urandom % 10) == 0);
            if ($urandom % 5 == 0) repeat ($urandom % 4) @(negedge clk);
        end

        waited = 0;
        while (expect_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) stop_with_error("commits were missing at the end of the run");
        end
        repeat (4) @(negedge clk); // quiet time to catch stray commits.
        sweep_regs();
        $display("All checks passed");
        $finish;
    end

endmodule

/* verilog.f */
pipe_pkg.sv
pipe_reg.sv
mem_stage.sv
data_ram.sv
reg_file.sv
mem_wb_top.sv
tb_mem_wb.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_mem_wb \
    -Mdir obj_dir -o sim_tb > sim.log 2>&1 || { echo "build failed, see sim.log"; exit 1; }
./obj_dir/sim_tb >> sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
